/* tb.f */
hdl/cache_pkg.sv
hdl/tag_data_ram.sv
hdl/icache.sv
hdl/load_unit.sv
hdl/mem_arbiter.sv
hdl/fetch_load_top.sv
verification/mem_model.sv
verification/tb_top.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_top -f tb.f
	./obj_dir/Vtb_top | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* verification/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int mem_latency = 6;
    localparam int n_cold = 6;
    localparam int n_hit = 16;
    localparam int n_lru = 6;
    localparam int n_shared = 2;
    localparam int n_random = 200;
    // a random step may carry a fetch and a load
    localparam int n_access = n_cold + n_hit + n_lru + n_shared + 2 * n_random;
    localparam int timeout_cycles = n_access * (mem_latency + 10) + 200;
    localparam int wait_limit = 4 * mem_latency + 20;

    logic              clk = 1'b0;
    logic              reset;
    logic              inst_en;
    logic              load_en;
    logic              stall, inst_valid, load_busy, load_valid;
    logic              mem_rd_req, mem_ret_valid;
    cache_pkg::bus32_t pc, inst, load_addr, load_data, mem_rd_addr;
    cache_pkg::line_t  mem_ret_data;
    int                strobe_count;
    int                bad_strobes;

    int                errors = 0;
    int                checks = 0;
    int                exp_strobes = 0;
    string             test_name = "reset";
    cache_pkg::bus32_t fetch_exp [$];
    cache_pkg::bus32_t load_exp [$];

    // two-entry recency model per set
    logic [cache_pkg::tag_w-1:0] mru_tag [cache_pkg::set_num];
    logic [cache_pkg::tag_w-1:0] lru_tag [cache_pkg::set_num];
    logic                        mru_v [cache_pkg::set_num];
    logic                        lru_v [cache_pkg::set_num];

    fetch_load_top i_fetch_load_top (.*);

    mem_model #(.latency(mem_latency)) i_mem_model (.*);

    always #4 clk = ~clk;

    function automatic cache_pkg::bus32_t mem_word(cache_pkg::bus32_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic bit predict_hit(cache_pkg::bus32_t addr);
        logic [cache_pkg::tag_w-1:0]   tag;
        logic [cache_pkg::index_w-1:0] idx;
        tag = addr[31:12];
        idx = addr[11:5];
        if (mru_v[idx] && mru_tag[idx] == tag) begin
            return 1'b1;
        end
        if (lru_v[idx] && lru_tag[idx] == tag) begin
            lru_tag[idx] = mru_tag[idx];
            mru_tag[idx] = tag;
            return 1'b1;
        end
        // miss pushes out the older line
        lru_tag[idx] = mru_tag[idx];
        lru_v[idx] = mru_v[idx];
        mru_tag[idx] = tag;
        mru_v[idx] = 1'b1;
        return 1'b0;
    endfunction

    task automatic check(input string name, input cache_pkg::bus32_t exp,
                         input cache_pkg::bus32_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic fetch_word(input cache_pkg::bus32_t addr, output bit hit);
        int cycles;
        bit exp_hit;
        exp_hit = predict_hit(addr);
        if (!exp_hit) begin
            exp_strobes++;
        end
        @(posedge clk);
        #1;
        inst_en = 1'b1;
        pc = addr;
        cycles = 0;
        @(negedge clk);
        while (stall && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        // accept edge
        @(posedge clk);
        fetch_exp.push_back(mem_word(addr));
        #1;
        inst_en = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!inst_valid && cycles < wait_limit);
        if (!inst_valid) begin
            errors++;
            $display("fetch at %h got no inst_valid", addr);
        end else if (exp_hit) begin
            check({test_name, " hit latency"}, 1, cycles);
        end
        // the DUT hit when it answered in the cycle after accept
        hit = inst_valid && cycles == 1;
    endtask

    task automatic load_word(input cache_pkg::bus32_t addr);
        int cycles;
        exp_strobes++;
        @(posedge clk);
        #1;
        load_en = 1'b1;
        load_addr = addr;
        cycles = 0;
        @(negedge clk);
        while (load_busy && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        load_exp.push_back(mem_word(addr));
        #1;
        load_en = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!load_valid && cycles < wait_limit);
        if (!load_valid) begin
            errors++;
            $display("load at %h got no load_valid", addr);
        end
    endtask

    // each result pulse against the oldest expected value
    always @(negedge clk) begin
        if (inst_valid && !reset) begin
            if (fetch_exp.size() == 0) begin
                errors++;
                $display("inst_valid came without a fetch in flight");
            end else begin
                check({test_name, " fetch"}, fetch_exp.pop_front(), inst);
            end
        end
        if (load_valid && !reset) begin
            if (load_exp.size() == 0) begin
                errors++;
                $display("load_valid came without a load in flight");
            end else begin
                check({test_name, " load"}, load_exp.pop_front(), load_data);
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        cache_pkg::bus32_t a;
        bit                hit;
        int                s0;
        void'($urandom(32'h3ec4));
        reset = 1'b1;
        inst_en = 1'b0;
        pc = '0;
        load_en = 1'b0;
        load_addr = '0;
        for (int s = 0; s < cache_pkg::set_num; s++) begin
            mru_v[s] = 1'b0;
            lru_v[s] = 1'b0;
        end
        // three reset cycles, stall sampled inside them
        @(posedge clk);
        @(negedge clk);
        check("reset stall high", 1, {31'b0, stall});
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check("reset outputs", 0, {27'b0, stall, inst_valid, load_busy, load_valid, mem_rd_req});

        test_name = "cold miss";
        for (int i = 0; i < n_cold; i++) begin
            s0 = strobe_count;
            fetch_word(32'h0000_2000 + 32'(i * 36), hit);
            check("cold miss strobe", s0 + 1, strobe_count);
        end

        test_name = "hit";
        for (int i = 0; i < n_hit; i++) begin
            fetch_word(32'h0000_2000 + 32'(i * 4), hit);
            check("hit expected", 1, {31'b0, hit});
        end
        check("hit strobes", exp_strobes, strobe_count);

        // three lines on set 2
        test_name = "lru";
        fetch_word(32'h0004_0040, hit);
        fetch_word(32'h0005_0040, hit);
        fetch_word(32'h0004_0044, hit);
        fetch_word(32'h0006_0048, hit);
        fetch_word(32'h0004_004c, hit);
        check("lru a kept", 1, {31'b0, hit});
        fetch_word(32'h0005_0050, hit);
        check("lru b evicted", 0, {31'b0, hit});
        check("lru strobes", exp_strobes, strobe_count);

        test_name = "shared port";
        s0 = strobe_count;
        fork
            fetch_word(32'h0008_0104, hit);
            load_word(32'h0009_0208);
        join
        check("shared strobes", s0 + 2, strobe_count);

        test_name = "random";
        for (int i = 0; i < n_random; i++) begin
            a = {20'h00010 + 20'($urandom % 3), 7'($urandom % 4), 3'($urandom % 8), 2'b00};
            if ($urandom % 4 == 0) begin
                fork
                    fetch_word(a, hit);
                    load_word({20'h00100 + 20'($urandom % 4), 7'($urandom), 3'($urandom), 2'b00});
                join
            end else begin
                fetch_word(a, hit);
            end
        end
        check("random strobes", exp_strobes, strobe_count);

        repeat (2) @(posedge clk);
        check("memory protocol", 0, bad_strobes);
        if (fetch_exp.size() != 0 || load_exp.size() != 0) begin
            errors++;
            $display("%0d fetches and %0d loads never returned", fetch_exp.size(),
                     load_exp.size());
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/mem_model.sv */
`timescale 1ns/1ps

module mem_model #(
    parameter int latency = 6
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_rd_req,
    input  cache_pkg::bus32_t mem_rd_addr,
    output logic              mem_ret_valid,
    output cache_pkg::line_t  mem_ret_data,
    output int                strobe_count,
    output int                bad_strobes
);

    logic              req_seen;
    logic              reset_seen;
    cache_pkg::bus32_t addr_seen;
    cache_pkg::bus32_t line_addr;
    logic              ret_valid_q = 1'b0;
    cache_pkg::line_t  ret_data_q = '0;
    int                strobes = 0;
    int                bad = 0;
    int                wait_cnt = 0;

    // word i of the line at base holds the rule value of base + 4i
    function automatic cache_pkg::line_t line_at(cache_pkg::bus32_t base);
        cache_pkg::line_t  line;
        cache_pkg::bus32_t a;
        for (int i = 0; i < cache_pkg::words_per_line; i++) begin
            a = base + 32'(4 * i);
            line[32*i +: 32] = {a[31:2], 2'b00} ^ 32'h5a5a_c3c3;
        end
        return line;
    endfunction

    // sample on the edge, answer 1 ns later
    always @(posedge clk) begin
        req_seen = mem_rd_req;
        addr_seen = mem_rd_addr;
        reset_seen = reset;
        #1;
        ret_valid_q = 1'b0;
        if (reset_seen) begin
            wait_cnt = 0;
            strobes = 0;
        end else begin
            if (wait_cnt != 0) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    ret_valid_q = 1'b1;
                    ret_data_q = line_at(line_addr);
                end
            end
            if (req_seen) begin
                strobes = strobes + 1;
                // one read in flight, line aligned
                if (wait_cnt != 0 || addr_seen[4:0] != 5'd0) begin
                    bad = bad + 1;
                end
                line_addr = addr_seen;
                wait_cnt = latency;
            end
        end
    end

    assign mem_ret_valid = ret_valid_q;
    assign mem_ret_data = ret_data_q;
    assign strobe_count = strobes;
    assign bad_strobes = bad;

endmodule

/* hdl/fetch_load_top.sv */
`timescale 1ns/1ps

module fetch_load_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              inst_en,
    input  cache_pkg::bus32_t pc,
    output logic              stall,
    output cache_pkg::bus32_t inst,
    output logic              inst_valid,
    input  logic              load_en,
    input  cache_pkg::bus32_t load_addr,
    output logic              load_busy,
    output cache_pkg::bus32_t load_data,
    output logic              load_valid,
    output logic              mem_rd_req,
    output cache_pkg::bus32_t mem_rd_addr,
    input  logic              mem_ret_valid,
    input  cache_pkg::line_t  mem_ret_data
);

    logic              icache_rd_req;
    cache_pkg::bus32_t icache_rd_addr;
    logic              icache_ret_valid;
    logic              load_rd_req;
    cache_pkg::bus32_t load_rd_addr;
    logic              load_ret_valid;
    cache_pkg::line_t  ret_data;

    icache i_icache (
        .clk(clk),
        .reset(reset),
        .inst_en(inst_en),
        .pc(pc),
        .stall(stall),
        .inst(inst),
        .inst_valid(inst_valid),
        .rd_req(icache_rd_req),
        .rd_addr(icache_rd_addr),
        .ret_valid(icache_ret_valid),
        .ret_data(ret_data)
    );

    load_unit i_load_unit (
        .clk(clk),
        .reset(reset),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_busy(load_busy),
        .load_data(load_data),
        .load_valid(load_valid),
        .rd_req(load_rd_req),
        .rd_addr(load_rd_addr),
        .ret_valid(load_ret_valid),
        .ret_data(ret_data)
    );

    mem_arbiter i_mem_arbiter (
        .clk(clk),
        .reset(reset),
        .icache_rd_req(icache_rd_req),
        .icache_rd_addr(icache_rd_addr),
        .icache_ret_valid(icache_ret_valid),
        .load_rd_req(load_rd_req),
        .load_rd_addr(load_rd_addr),
        .load_ret_valid(load_ret_valid),
        .ret_data(ret_data),
        .mem_rd_req(mem_rd_req),
        .mem_rd_addr(mem_rd_addr),
        .mem_ret_valid(mem_ret_valid),
        .mem_ret_data(mem_ret_data)
    );

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic              icache_rd_req,
    input  cache_pkg::bus32_t icache_rd_addr,
    output logic              icache_ret_valid,
    input  logic              load_rd_req,
    input  cache_pkg::bus32_t load_rd_addr,
    output logic              load_ret_valid,
    output cache_pkg::line_t  ret_data,
    output logic              mem_rd_req,
    output cache_pkg::bus32_t mem_rd_addr,
    input  logic              mem_ret_valid,
    input  cache_pkg::line_t  mem_ret_data
);

    localparam int addr_w = cache_pkg::addr_w;
    localparam int offset_w = cache_pkg::offset_w;

    cache_pkg::arb_state_t state;
    cache_pkg::requester_t owner;
    cache_pkg::requester_t last;
    cache_pkg::requester_t grant;
    cache_pkg::bus32_t     grant_addr;
    logic                  any_req;

    assign any_req = icache_rd_req || load_rd_req;

    // on a tie the side not served last wins
    always_comb begin
        if (icache_rd_req && load_rd_req) begin
            grant = (last == cache_pkg::req_icache) ? cache_pkg::req_load : cache_pkg::req_icache;
        end else if (load_rd_req) begin
            grant = cache_pkg::req_load;
        end else begin
            grant = cache_pkg::req_icache;
        end
    end

    assign grant_addr = (grant == cache_pkg::req_load) ? load_rd_addr : icache_rd_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::arb_idle;
            owner <= cache_pkg::req_icache;
            last <= cache_pkg::req_load;
            mem_rd_req <= 1'b0;
        end else begin
            mem_rd_req <= 1'b0;
            case (state)
                cache_pkg::arb_idle: begin
                    if (any_req) begin
                        state <= cache_pkg::arb_busy;
                        owner <= grant;
                        last <= grant;
                        mem_rd_req <= 1'b1;
                    end
                end
                cache_pkg::arb_busy: begin
                    if (mem_ret_valid) begin
                        state <= cache_pkg::arb_idle;
                    end
                end
                default: state <= cache_pkg::arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::arb_idle && any_req) begin
            mem_rd_addr <= {grant_addr[addr_w-1:offset_w], {offset_w{1'b0}}};
        end
    end

    // return pulse goes to the owner only
    assign icache_ret_valid = mem_ret_valid && (owner == cache_pkg::req_icache);
    assign load_ret_valid = mem_ret_valid && (owner == cache_pkg::req_load);
    assign ret_data = mem_ret_data;

    // the owner keeps its request up until its line returns
    a_owner_holds_req: assert property (
        @(posedge clk) disable iff (reset)
        state == cache_pkg::arb_busy |->
            (owner == cache_pkg::req_icache ? icache_rd_req : load_rd_req)
    );

    a_no_return_idle: assert property (
        @(posedge clk) disable iff (reset)
        mem_ret_valid |-> state == cache_pkg::arb_busy
    );

endmodule

/* hdl/load_unit.sv */
`timescale 1ns/1ps

module load_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              load_en,
    input  cache_pkg::bus32_t load_addr,
    output logic              load_busy,
    output cache_pkg::bus32_t load_data,
    output logic              load_valid,
    output logic              rd_req,
    output cache_pkg::bus32_t rd_addr,
    input  logic              ret_valid,
    input  cache_pkg::line_t  ret_data
);

    localparam int addr_w = cache_pkg::addr_w;
    localparam int data_w = cache_pkg::data_w;
    localparam int offset_w = cache_pkg::offset_w;

    cache_pkg::load_state_t state;
    cache_pkg::bus32_t      addr_q;
    logic [offset_w-3:0]    word_sel;

    assign word_sel = addr_q[offset_w-1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::load_idle;
            load_valid <= 1'b0;
        end else begin
            load_valid <= 1'b0;
            case (state)
                cache_pkg::load_idle: begin
                    if (load_en) begin
                        state <= cache_pkg::load_wait;
                    end
                end
                cache_pkg::load_wait: begin
                    if (ret_valid) begin
                        state <= cache_pkg::load_idle;
                        load_valid <= 1'b1;
                    end
                end
                default: state <= cache_pkg::load_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::load_idle && load_en) begin
            addr_q <= load_addr;
        end
        // pick the word out of the returned line
        if (state == cache_pkg::load_wait && ret_valid) begin
            load_data <= ret_data[word_sel*data_w +: data_w];
        end
    end

    assign load_busy = (state == cache_pkg::load_wait);
    assign rd_req = (state == cache_pkg::load_wait);
    assign rd_addr = {addr_q[addr_w-1:offset_w], {offset_w{1'b0}}};

    // the line only comes back while a load waits
    a_return_while_waiting: assert property (
        @(posedge clk) disable iff (reset)
        ret_valid |-> state == cache_pkg::load_wait
    );

endmodule

/* hdl/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_en,
    input  cache_pkg::bus32_t pc,
    output logic             stall,
    output cache_pkg::bus32_t inst,
    output logic             inst_valid,
    output logic             rd_req,
    output cache_pkg::bus32_t rd_addr,
    input  logic             ret_valid,
    input  cache_pkg::line_t ret_data
);

    localparam int addr_w = cache_pkg::addr_w;
    localparam int data_w = cache_pkg::data_w;
    localparam int tag_w = cache_pkg::tag_w;
    localparam int index_w = cache_pkg::index_w;
    localparam int offset_w = cache_pkg::offset_w;
    localparam int words_per_line = cache_pkg::words_per_line;
    localparam int set_num = cache_pkg::set_num;
    localparam int tagv_w = cache_pkg::tagv_w;

    // fetch address registered at accept
    logic             pre_en;
    cache_pkg::bus32_t pre_pc;

    logic [tag_w-1:0]       pre_tag;
    logic [index_w-1:0]     pre_idx;
    logic [offset_w-3:0]    word_sel;
    logic [index_w-1:0]     ram_idx;

    cache_pkg::bus32_t      bank_rdata [2][words_per_line];
    logic [tag_w-1:0]       tag_rdata [2];
    logic [tagv_w-1:0]      tagv [2];
    logic [1:0]             way_hit;
    logic [1:0]             fill_we;

    logic [set_num-1:0]     valid [2];
    logic [set_num-1:0]     lru;
    logic                   lru_pick;

    logic                   fill_done;
    logic                   lookup;
    logic                   hit;
    logic                   miss;
    logic                   fill;

    assign pre_tag = pre_pc[addr_w-1 -: tag_w];
    assign pre_idx = pre_pc[offset_w +: index_w];
    assign word_sel = pre_pc[offset_w-1:2];

    // hold the read index while stalled
    assign ram_idx = stall ? pre_idx : pc[offset_w +: index_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            pre_en <= 1'b0;
        end else if (fill_done) begin
            pre_en <= 1'b0;
        end else if (!stall) begin
            pre_en <= inst_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pre_pc <= pc;
        end
    end

    // second stall cycle while the fill lands in the rams
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_done <= 1'b0;
        end else begin
            fill_done <= fill;
        end
    end

    assign lookup = pre_en && !fill_done;
    assign hit = lookup && (|way_hit);
    assign miss = lookup && !(|way_hit);
    assign fill = miss && ret_valid;

    assign lru_pick = lru[pre_idx];
    assign fill_we[0] = fill && !lru_pick;
    assign fill_we[1] = fill && lru_pick;

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < words_per_line; b++) begin : g_bank
            tag_data_ram #(
                .width(data_w),
                .depth(set_num)
            ) i_bank (
                .clk(clk),
                .we(fill_we[w]),
                .waddr(pre_idx),
                .wdata(ret_data[b*data_w +: data_w]),
                .raddr(ram_idx),
                .rdata(bank_rdata[w][b])
            );
        end

        tag_data_ram #(
            .width(tag_w),
            .depth(set_num)
        ) i_tag (
            .clk(clk),
            .we(fill_we[w]),
            .waddr(pre_idx),
            .wdata(pre_tag),
            .raddr(ram_idx),
            .rdata(tag_rdata[w])
        );

        // valid comes from flops, tag from ram
        assign tagv[w] = {valid[w][pre_idx], tag_rdata[w]};
        assign way_hit[w] = (tagv[w] == {1'b1, pre_tag});
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid[0] <= '0;
            valid[1] <= '0;
        end else if (fill) begin
            valid[lru_pick][pre_idx] <= 1'b1;
        end
    end

    // lru bit names the way to replace next
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (hit) begin
            lru[pre_idx] <= way_hit[0];
        end else if (fill) begin
            lru[pre_idx] <= !lru_pick;
        end
    end

    always_comb begin
        if (way_hit[0]) begin
            inst = bank_rdata[0][word_sel];
        end else if (way_hit[1]) begin
            inst = bank_rdata[1][word_sel];
        end else begin
            inst = ret_data[word_sel*data_w +: data_w];
        end
    end

    assign inst_valid = hit || fill;
    assign stall = reset || miss || fill_done;

    assign rd_req = miss;
    assign rd_addr = {pre_pc[addr_w-1:offset_w], {offset_w{1'b0}}};

    // a line may live in only one way of a set
    a_one_way_hit: assert property (
        @(posedge clk) disable iff (reset)
        pre_en |-> !(way_hit[0] && way_hit[1])
    );

endmodule

/* hdl/tag_data_ram.sv */
`timescale 1ns/1ps

module tag_data_ram #(
    parameter int width = 32,
    parameter int depth = 128
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [width-1:0]         wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output logic [width-1:0]         rdata
);

    logic [width-1:0] mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old data on collision
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* hdl/cache_pkg.sv */
package cache_pkg;

    // address and data geometry
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int line_w = 256;

    // address split is tag 31..12, index 11..5, offset 4..0
    localparam int tag_w = 20;
    localparam int index_w = 7;
    localparam int offset_w = 5;

    localparam int words_per_line = 8;
    localparam int set_num = 128;

    // tag with its valid bit on top
    localparam int tagv_w = 21;

    typedef logic [addr_w-1:0] bus32_t;

    // word i sits at bits 32i+31..32i
    typedef logic [line_w-1:0] line_t;

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_t;

    typedef enum logic {
        load_idle,
        load_wait
    } load_state_t;

    // owner of the shared memory port
    typedef enum logic {
        req_icache,
        req_load
    } requester_t;

endpackage
